//--- src/etx_pkg.sv
`default_nettype none

package etx_pkg;

   //####################
   // Widths
   //####################
   localparam int PW      = 104;  // flat mesh packet
   localparam int AW      = 32;
   localparam int DW      = 32;
   localparam int WORD_W  = 64;   // one link word
   localparam int FRAME_W = 4;    // frame bit per byte pair
   localparam int ID_W    = 12;   // upper dstaddr bits

   //####################
   // Packet fields
   //####################
   localparam int WRITE_BIT    = 0;
   localparam int DATAMODE_LSB = 1;
   localparam int DATAMODE_W   = 2;
   localparam int CTRLMODE_LSB = 3;
   localparam int CTRLMODE_W   = 5;
   localparam int DSTADDR_LSB  = 8;
   localparam int DATA_LSB     = 40;
   localparam int SRCADDR_LSB  = 72;

   localparam logic [DATAMODE_W-1:0] DM_DOUBLE = 2'b11;  // 64-bit access

   // Frame nibbles, one bit per two bytes
   localparam logic [FRAME_W-1:0] FRAME_HEAD = 4'b0111;
   localparam logic [FRAME_W-1:0] FRAME_BODY = 4'b1111;

   // Address step between burst beats
   localparam logic [AW-1:0] BURST_STRIDE = 32'd8;

   // Engine states
   typedef enum logic [1:0] {
      IDLE  = 2'b00,
      START = 2'b01,  // header word
      ACK   = 2'b10,  // payload word
      BURST = 2'b11   // headerless payload beats
   } tx_state_t;

   // Top level defaults
   localparam int              DEFAULT_DEPTH = 4;
   localparam logic [ID_W-1:0] DEFAULT_ID    = 12'h810;

endpackage

`default_nettype wire

//--- src/etx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module etx_fifo
   import etx_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  wire           clk,
   input  wire           nreset,
   input  wire           push,        // strobe from system side
   input  wire  [PW-1:0] packet_in,
   input  wire           pop,         // one cycle per packet
   output logic          full,        // doubles as system wait
   output logic          valid,
   output logic [PW-1:0] packet_out   // head of queue
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [PW-1:0]    mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;   // occupancy
   logic             do_push;
   logic             do_pop;

   // Circular increment for any depth
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   assign full       = (count == CNT_W'(DEPTH));
   assign valid      = (count != '0);
   assign do_push    = push & ~full;   // offers while full are lost
   assign do_pop     = pop & valid;
   assign packet_out = mem[rd_ptr];

   // Packet storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= packet_in;
      end
   end

   // Pointers and count
   always_ff @(posedge clk) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push with pop
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/etx_protocol.sv
`timescale 1ns/1ps
`default_nettype none

module etx_protocol
   import etx_pkg::*;
#(
   parameter logic [ID_W-1:0] ID = DEFAULT_ID
) (
   input  wire                clk,
   input  wire                nreset,
   // Queue head
   input  wire                q_valid,
   input  wire  [PW-1:0]      q_packet,
   output logic               q_pop,
   // Config
   input  wire                tx_enable,
   input  wire                burst_enable,
   input  wire                ctrlmode_bypass,
   input  wire  [3:0]         ctrlmode,
   // Remote side waits
   input  wire                txi_wr_wait,
   input  wire                txi_rd_wait,
   // To serializer
   output logic               word_valid,
   output logic [WORD_W-1:0]  word_data,
   output logic [FRAME_W-1:0] word_frame,
   input  wire                word_ready,
   // Status
   output logic               tx_access,
   output logic               tx_burst
);

   tx_state_t             state;
   logic                  beat_armed;    // burst beat on offer
   logic [PW-1:0]         tx_packet;     // last packet handed over
   logic [PW-1:0]         cur_packet;    // head with override
   logic [PW-1:0]         pay_packet;
   logic [CTRLMODE_W-1:0] cur_ctrlmode;

   // Head fields
   logic                  h_write;
   logic [DATAMODE_W-1:0] h_datamode;
   logic [CTRLMODE_W-1:0] h_ctrlmode;
   logic [AW-1:0]         h_dstaddr;
   // In-flight fields
   logic                  t_write;
   logic [DATAMODE_W-1:0] t_datamode;
   logic [CTRLMODE_W-1:0] t_ctrlmode;
   logic [AW-1:0]         t_dstaddr;
   // Payload fields
   logic [DW-1:0]         p_data;
   logic [AW-1:0]         p_srcaddr;

   logic                  remote_wait;
   logic                  local_hit;
   logic                  head_ok;
   logic                  sent_match;
   logic                  head_match;
   logic                  addr_match;
   logic                  burst_go;
   logic                  burst_flag;
   logic                  pop_on_xfer;
   logic                  drop;
   logic [WORD_W-1:0]     head_word;
   logic [WORD_W-1:0]     pay_word;

   //####################
   // Field slicing
   //####################
   assign h_write    = q_packet[WRITE_BIT];
   assign h_datamode = q_packet[DATAMODE_LSB +: DATAMODE_W];
   assign h_ctrlmode = q_packet[CTRLMODE_LSB +: CTRLMODE_W];
   assign h_dstaddr  = q_packet[DSTADDR_LSB +: AW];

   assign t_write    = tx_packet[WRITE_BIT];
   assign t_datamode = tx_packet[DATAMODE_LSB +: DATAMODE_W];
   assign t_ctrlmode = tx_packet[CTRLMODE_LSB +: CTRLMODE_W];
   assign t_dstaddr  = tx_packet[DSTADDR_LSB +: AW];

   // Override replaces low ctrlmode bits and clears bit 4
   assign cur_ctrlmode = ctrlmode_bypass ? {1'b0, ctrlmode} : h_ctrlmode;

   always_comb begin
      cur_packet = q_packet;
      cur_packet[CTRLMODE_LSB +: CTRLMODE_W] = cur_ctrlmode;
   end

   // Held packet while the head already moved on
   always_ff @(posedge clk) begin
      if (pop_on_xfer && word_ready) begin
         tx_packet <= cur_packet;
      end
   end

   //####################
   // Eligibility & burst
   //####################
   assign remote_wait = txi_wr_wait | txi_rd_wait;
   assign local_hit   = q_valid & (h_dstaddr[AW-1 -: ID_W] == ID);   // own register space
   assign head_ok     = q_valid & tx_enable & ~remote_wait & ~local_hit;

   assign sent_match = t_write & (t_datamode == DM_DOUBLE) & (t_ctrlmode[3:0] == 4'b0000);
   assign head_match = h_write & (h_datamode == DM_DOUBLE) & (cur_ctrlmode[3:0] == 4'b0000);
   assign addr_match = ((t_dstaddr + BURST_STRIDE) == h_dstaddr);
   assign burst_go   = burst_enable & sent_match & head_match & addr_match & head_ok;
   assign burst_flag = burst_enable & head_match;   // header may open a burst

   //####################
   // State machine
   //####################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         state      <= IDLE;
         beat_armed <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (head_ok) begin
                  state <= START;
               end
            end
            START: begin
               if (word_ready) begin
                  state <= ACK;
               end
            end
            ACK: begin
               if (word_ready) begin
                  if (burst_go) begin
                     state      <= BURST;
                     beat_armed <= 1'b1;
                  end else if (head_ok) begin
                     state <= START;
                  end else begin
                     state <= IDLE;
                  end
               end
            end
            BURST: begin
               if (beat_armed) begin
                  if (word_ready) begin
                     beat_armed <= 1'b0;   // check next head one cycle later
                  end
               end else if (burst_go) begin
                  beat_armed <= 1'b1;
               end else if (head_ok) begin
                  state <= START;
               end else begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   //####################
   // Link words
   //####################
   assign pay_packet = (state == ACK) ? tx_packet : cur_packet;
   assign p_data     = pay_packet[DATA_LSB +: DW];
   assign p_srcaddr  = pay_packet[SRCADDR_LSB +: AW];

   assign head_word = {h_dstaddr[11:0], h_datamode, h_write, 1'b1,
                       h_dstaddr[27:12],
                       ~h_write, 5'b00000, burst_flag, 1'b0,
                       cur_ctrlmode[3:0], h_dstaddr[31:28],
                       16'h0000};
   assign pay_word  = {p_srcaddr[15:0], p_srcaddr[31:16], p_data[15:0], p_data[31:16]};

   assign pop_on_xfer = (state == START) | ((state == BURST) & beat_armed);
   assign drop        = (state == IDLE) & local_hit & tx_enable;   // no word for it

   assign word_valid = pop_on_xfer | (state == ACK);
   assign word_data  = (state == START) ? head_word : pay_word;
   assign word_frame = !word_valid      ? '0 :
                       (state == START) ? FRAME_HEAD :
                                          FRAME_BODY;

   assign q_pop     = (pop_on_xfer & word_ready) | drop;
   assign tx_access = word_valid & word_ready;
   assign tx_burst  = (state == BURST);

endmodule

`default_nettype wire

//--- src/etx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module etx_serializer
   import etx_pkg::*;
(
   input  wire                clk,
   input  wire                nreset,
   input  wire                word_valid,
   input  wire  [WORD_W-1:0]  word_data,
   input  wire  [FRAME_W-1:0] word_frame,
   output logic               word_ready,
   output logic [7:0]         txo_data,
   output logic               txo_frame
);

   logic [WORD_W-1:0]  shift_reg;   // MSB byte goes out first
   logic [FRAME_W-1:0] frame_nib;
   logic [2:0]         byte_cnt;    // byte on the wire
   logic               busy;
   logic               last_byte;
   logic               load;

   assign last_byte  = busy & (byte_cnt == 3'd7);
   assign word_ready = ~busy | last_byte;   // next word follows with no gap
   assign load       = word_valid & word_ready;

   //####################
   // Shift path
   //####################
   always_ff @(posedge clk) begin
      if (load) begin
         shift_reg <= word_data;
         frame_nib <= word_frame;
      end else if (busy) begin
         shift_reg <= {shift_reg[WORD_W-9:0], 8'h00};
      end
   end

   //####################
   // Byte counter
   //####################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         busy     <= 1'b0;
         byte_cnt <= 3'd0;
      end else if (load) begin
         busy     <= 1'b1;
         byte_cnt <= 3'd0;
      end else if (busy) begin
         byte_cnt <= byte_cnt + 3'd1;
         if (last_byte) begin
            busy <= 1'b0;   // drained
         end
      end
   end

   // Frame bit steps down the nibble every two bytes
   always_comb begin
      if (busy) begin
         txo_data  = shift_reg[WORD_W-1 -: 8];
         txo_frame = frame_nib[2'd3 - byte_cnt[2:1]];
      end else begin
         txo_data  = 8'h00;
         txo_frame = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- src/etx_top.sv
`timescale 1ns/1ps
`default_nettype none

module etx_top
   import etx_pkg::*;
#(
   parameter int              DEPTH = DEFAULT_DEPTH,
   parameter logic [ID_W-1:0] ID    = DEFAULT_ID
) (
   input  wire           clk,
   input  wire           nreset,
   // System side
   input  wire           etx_access,
   input  wire  [PW-1:0] etx_packet,
   output logic          etx_wait,        // queue full
   // Config
   input  wire           tx_enable,
   input  wire           burst_enable,
   input  wire           ctrlmode_bypass,
   input  wire  [3:0]    ctrlmode,
   // Remote side
   input  wire           txi_wr_wait,
   input  wire           txi_rd_wait,
   output logic [7:0]    txo_data,
   output logic          txo_frame,
   // Status
   output logic          tx_access,
   output logic          tx_burst
);

   // Queue to engine
   logic               q_valid;
   logic [PW-1:0]      q_packet;
   logic               q_pop;
   // Engine to serializer
   logic               word_valid;
   logic [WORD_W-1:0]  word_data;
   logic [FRAME_W-1:0] word_frame;
   logic               word_ready;

   etx_fifo #(.DEPTH(DEPTH)) u_fifo (
      .clk        (clk),
      .nreset     (nreset),
      .push       (etx_access),
      .packet_in  (etx_packet),
      .pop        (q_pop),
      .full       (etx_wait),
      .valid      (q_valid),
      .packet_out (q_packet)
   );

   etx_protocol #(.ID(ID)) u_protocol (
      .clk             (clk),
      .nreset          (nreset),
      .q_valid         (q_valid),
      .q_packet        (q_packet),
      .q_pop           (q_pop),
      .tx_enable       (tx_enable),
      .burst_enable    (burst_enable),
      .ctrlmode_bypass (ctrlmode_bypass),
      .ctrlmode        (ctrlmode),
      .txi_wr_wait     (txi_wr_wait),
      .txi_rd_wait     (txi_rd_wait),
      .word_valid      (word_valid),
      .word_data       (word_data),
      .word_frame      (word_frame),
      .word_ready      (word_ready),
      .tx_access       (tx_access),
      .tx_burst        (tx_burst)
   );

   etx_serializer u_serializer (
      .clk        (clk),
      .nreset     (nreset),
      .word_valid (word_valid),
      .word_data  (word_data),
      .word_frame (word_frame),
      .word_ready (word_ready),
      .txo_data   (txo_data),
      .txo_frame  (txo_frame)
   );

endmodule

`default_nettype wire

//--- bench/etx_sva.sv
`timescale 1ns/1ps
`default_nettype none

module etx_sva
   import etx_pkg::*;
(
   input wire       clk,
   input wire       nreset,
   input wire       q_pop,
   input wire       q_valid,
   input wire       word_ready,
   input wire       tx_burst,
   input wire       burst_enable,
   input tx_state_t state
);

   // Head removed only when present
   a_pop_valid: assert property (@(posedge clk) disable iff (!nreset)
      q_pop |-> q_valid) else $error("q_pop without q_valid");

   // Payload states are reached only through a header or a burst
   a_state_legal: assert property (@(posedge clk) disable iff (!nreset)
      (state == IDLE) |=> state inside {IDLE, START})
      else $error("IDLE left for a payload state");

   // Header waits for the serializer, then payload
   a_start_hold: assert property (@(posedge clk) disable iff (!nreset)
      (state == START && !word_ready) |=> state == START) else $error("START not held");

   a_start_ack: assert property (@(posedge clk) disable iff (!nreset)
      (state == START && word_ready) |=> state == ACK) else $error("START not followed by ACK");

   a_burst_en: assert property (@(posedge clk) disable iff (!nreset)
      tx_burst |-> burst_enable) else $error("burst without burst_enable");

endmodule

bind etx_protocol etx_sva u_sva (
   .clk          (clk),
   .nreset       (nreset),
   .q_pop        (q_pop),
   .q_valid      (q_valid),
   .word_ready   (word_ready),
   .tx_burst     (tx_burst),
   .burst_enable (burst_enable),
   .state        (state)
);

`default_nettype wire

//--- bench/etx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module etx_tb
   import etx_pkg::*;
();

   localparam int          DEPTH   = 4;
   localparam logic [11:0] ID      = 12'h810;
   localparam logic [31:0] SEED    = 32'd80698;
   localparam int          TIMEOUT = 3000;   // cycles per wait loop
   localparam int          NPKT    = 24;

   logic          clk;
   logic          nreset;
   logic          etx_access;
   logic [PW-1:0] etx_packet;
   logic          tx_enable;
   logic          burst_enable;
   logic          ctrlmode_bypass;
   logic [3:0]    ctrlmode;
   logic          txi_wr_wait;
   logic          txi_rd_wait;
   logic          etx_wait;
   logic [7:0]    txo_data;
   logic          txo_frame;
   logic          tx_access;
   logic          tx_burst;

   // Model state
   logic [63:0]   exp_head[$];
   logic [63:0]   exp_pay[$];
   bit            exp_bok[$];       // beat may go headerless
   logic [PW-1:0] prev_pkt;
   logic [31:0]   last_addr;
   logic [31:0]   lfsr;
   logic [63:0]   hdr_pay;
   logic [63:0]   mon_word;
   logic [7:0]    mon_frames;
   bit            hdr_seen;
   bit            active;
   bit            pending;
   bit            wait_mode;
   bit            xfer_burst;       // tx_burst at hand-over
   int            wait_hold;        // calls left at current wait levels
   int            mon_cnt;
   int            start_cyc;
   int            cyc = 0;
   int            last_clear = 0;
   int            errors;
   int            checks;
   int            tests;
   int            accepted;
   int            decoded;
   int            dropped;
   int            err_mark;
   string         test_name;

   etx_top #(.DEPTH(DEPTH), .ID(ID)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //####################
   // Random and model
   //####################
   function automatic logic next_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32,22,2,1
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
      return v;
   endfunction

   function automatic logic [63:0] head_of(input logic [PW-1:0] p, input logic ben);
      logic        w;
      logic        bf;
      logic [1:0]  dm;
      logic [3:0]  cm;
      logic [31:0] a;
      w  = p[0];
      dm = p[2:1];
      cm = p[6:3];
      a  = p[39:8];
      bf = ben & w & (dm == 2'b11) & (cm == 4'h0);   // burst flag
      return {a[11:0], dm, w, 1'b1, a[27:12], ~w, 5'b00000, bf, 1'b0, cm, a[31:28], 16'h0000};
   endfunction

   function automatic logic [63:0] pay_of(input logic [PW-1:0] p);
      return {p[87:72], p[103:88], p[55:40], p[71:56]};
   endfunction

   function automatic bit dw_write(input logic [PW-1:0] p);
      return p[0] && p[2:1] == 2'b11 && p[6:3] == 4'h0;
   endfunction

   // Accepted packet into the model, override applied
   task automatic model_accept(input logic [PW-1:0] p);
      logic [PW-1:0] q;
      q = p;
      if (ctrlmode_bypass) q[7:3] = {1'b0, ctrlmode};
      if (q[39:28] == ID) begin
         dropped++;   // own register space
      end else begin
         exp_head.push_back(head_of(q, burst_enable));
         exp_pay.push_back(pay_of(q));
         exp_bok.push_back(burst_enable && dw_write(prev_pkt) && dw_write(q) &&
                           q[39:8] == prev_pkt[39:8] + 32'd8);
         prev_pkt = q;
         accepted++;
      end
   endtask

   function automatic logic [PW-1:0] gen_packet(input bit burst_mode, input bit id_mode);
      logic [31:0] src;
      logic [31:0] data;
      logic [31:0] addr;
      logic [31:0] r;
      logic [4:0]  cm;
      logic [1:0]  dm;
      logic        w;
      src  = rand_bits(32);
      data = rand_bits(32);
      addr = rand_bits(32);
      r    = rand_bits(8);
      cm   = r[4:0];
      dm   = r[6:5];
      w    = r[7];
      if (id_mode && rand_bits(2) == 32'd0) addr[31:20] = ID;
      if (burst_mode) begin
         w  = 1'b1;
         dm = 2'b11;
         cm = 5'd0;
         if (rand_bits(2) != 32'd0) addr = last_addr + 32'd8;   // continue run
      end
      last_addr = addr;
      return {src, data, addr, cm, dm, w};
   endfunction

   //####################
   // Stimulus
   //####################
   task automatic set_waits();
      if (wait_hold > 0) begin
         wait_hold--;   // keep current levels
      end else begin
         txi_wr_wait = (rand_bits(2) == 32'd0);
         txi_rd_wait = (rand_bits(2) == 32'd0);
         wait_hold   = rand_bits(5);   // stretch of 0 to 31 calls
      end
   endtask

   task automatic offer_packet(input logic [PW-1:0] p, output bit acc);
      @(negedge clk);
      etx_access = 1'b1;
      etx_packet = p;
      acc = !etx_wait;   // stable until the next edge
      if (acc) model_accept(p);
      @(negedge clk);
      etx_access = 1'b0;
      if (wait_mode) set_waits();
   endtask

   task automatic send_packet(input logic [PW-1:0] p);
      bit acc;
      int t;
      acc = 0;
      t   = 0;
      while (!acc && t < TIMEOUT) begin
         offer_packet(p, acc);
         t++;
      end
      if (!acc) begin
         $display("%s: queue stayed full, packet never accepted", test_name);
         errors++;
      end
   endtask

   task automatic gap();
      int n;
      n = rand_bits(2);
      repeat (n) begin
         @(negedge clk);
         if (wait_mode) set_waits();
      end
   endtask

   task automatic drain();
      int t;
      t = 0;
      while ((exp_head.size() != 0 || hdr_seen || active || pending) && t < TIMEOUT) begin
         @(negedge clk);
         if (wait_mode) set_waits();
         t++;
      end
      if (t >= TIMEOUT) begin
         $display("%s: stream stalled with %0d packets outstanding", test_name, exp_head.size());
         errors++;
      end
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      repeat (4) @(negedge clk);
   endtask

   task automatic run_packets(input int n, input bit burst_mode, input bit id_mode);
      for (int i = 0; i < n; i++) begin
         send_packet(gen_packet(burst_mode, id_mode));
         gap();
      end
      drain();
   endtask

   task automatic finish_test();
      $display("%-14s done, %0d errors", test_name, errors - err_mark);
      tests++;
      err_mark = errors;
   endtask

   //####################
   // Stream monitor
   //####################
   task automatic check_word(input logic [63:0] w, input logic [7:0] f, input int start,
                             input bit burst);
      logic [63:0] ep;
      bit          eb;
      bit          exp_burst;
      checks++;
      if (f == 8'b0011_1111) begin   // header
         if (hdr_seen) begin
            $display("%s: header arrived before the previous payload", test_name);
            errors++;
         end
         if (exp_head.size() == 0) begin
            $display("%s: header word with no packet expected", test_name);
            errors++;
         end else begin
            if (w != exp_head[0])
               $display("Mismatch %s: expected %h actual %h", test_name, exp_head[0], w);
            if (w != exp_head[0]) errors++;
            if (ctrlmode_bypass && w[23:20] != ctrlmode) begin
               $display("Mismatch %s: expected %h actual %h", test_name, ctrlmode, w[23:20]);
               errors++;
            end
            if (start - last_clear > 12) begin
               $display("%s: header started while remote wait was high", test_name);
               errors++;
            end
            if (burst) begin   // header goes out of START
               $display("Mismatch %s: expected tx_burst %0d actual %0d",
                        test_name, 1'b0, burst);
               errors++;
            end
            void'(exp_head.pop_front());
            hdr_pay  = exp_pay.pop_front();
            eb       = exp_bok.pop_front();
            hdr_seen = 1;
         end
      end else if (f == 8'hff) begin   // payload
         if (hdr_seen) begin
            ep        = hdr_pay;
            hdr_seen  = 0;
            exp_burst = 0;
         end else if (exp_pay.size() == 0) begin
            $display("%s: burst beat with no packet expected", test_name);
            errors++;
            return;
         end else begin
            void'(exp_head.pop_front());
            ep        = exp_pay.pop_front();
            eb        = exp_bok.pop_front();
            exp_burst = 1;   // beat rides in BURST
            if (!eb) begin
               $display("%s: headerless payload where no burst is allowed", test_name);
               errors++;
            end
         end
         decoded++;
         if (w != ep) begin
            $display("Mismatch %s: expected %h actual %h", test_name, ep, w);
            errors++;
         end
         if (burst != exp_burst) begin
            $display("Mismatch %s: expected tx_burst %0d actual %0d",
                     test_name, exp_burst, burst);
            errors++;
         end
      end else begin
         $display("%s: bad frame pattern %b", test_name, f);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (!txi_wr_wait && !txi_rd_wait) last_clear <= cyc;
   end

   always @(negedge clk) begin
      if (!nreset) begin
         pending = 0;
         active  = 0;
      end else begin
         if (!tx_enable && txo_frame) begin
            $display("%s: txo_frame high with transmit disabled", test_name);
            errors++;
         end
         if (pending) begin   // bytes follow the transfer cycle
            active    = 1;
            pending   = 0;
            mon_cnt   = 0;
            start_cyc = cyc;
         end
         if (active) begin
            mon_word   = {mon_word[55:0], txo_data};
            mon_frames = {mon_frames[6:0], txo_frame};
            mon_cnt++;
            if (mon_cnt == 8) begin
               check_word(mon_word, mon_frames, start_cyc, xfer_burst);
               active = 0;
            end
         end
         if (tx_access) begin
            pending    = 1;
            xfer_burst = tx_burst;
         end
      end
   end

   //####################
   // Test sequence
   //####################
   initial begin
      bit acc;
      nreset          = 1'b0;
      etx_access      = 1'b0;
      etx_packet      = '0;
      tx_enable       = 1'b1;
      burst_enable    = 1'b0;
      ctrlmode_bypass = 1'b0;
      ctrlmode        = 4'h0;
      txi_wr_wait     = 1'b0;
      txi_rd_wait     = 1'b0;
      lfsr            = SEED;
      prev_pkt        = '0;
      last_addr       = '0;
      wait_mode       = 0;
      wait_hold       = 0;
      hdr_seen        = 0;
      xfer_burst      = 0;
      errors          = 0;
      checks          = 0;
      tests           = 0;
      accepted        = 0;
      decoded         = 0;
      dropped         = 0;
      err_mark        = 0;
      repeat (5) @(posedge clk);
      @(negedge clk) nreset = 1'b1;

      test_name = "single";
      run_packets(NPKT, 0, 0);
      finish_test();

      test_name = "burst";
      burst_enable = 1'b1;
      run_packets(NPKT, 1, 0);
      burst_enable = 1'b0;   // runs must now carry headers
      run_packets(NPKT / 2, 1, 0);
      finish_test();

      test_name = "id_override";
      ctrlmode_bypass = 1'b1;
      ctrlmode = 4'(rand_bits(4));
      run_packets(NPKT, 0, 1);
      ctrlmode_bypass = 1'b0;
      finish_test();

      test_name = "backpressure";
      tx_enable = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         offer_packet(gen_packet(0, 0), acc);
         if (!acc) begin
            $display("%s: packet refused before queue was full", test_name);
            errors++;
         end
      end
      checks++;
      if (!etx_wait) begin
         $display("%s: etx_wait low with %0d packets queued", test_name, DEPTH);
         errors++;
      end
      offer_packet(gen_packet(0, 0), acc);
      if (acc) begin
         $display("%s: packet accepted into a full queue", test_name);
         errors++;
      end
      repeat (20) @(negedge clk);
      tx_enable = 1'b1;
      drain();
      finish_test();

      test_name = "remote_wait";
      wait_mode = 1;
      burst_enable = 1'b1;
      run_packets(NPKT, 1, 0);
      run_packets(NPKT, 0, 0);
      wait_mode = 0;
      burst_enable = 1'b0;
      checks++;
      if (decoded != accepted) begin
         $display("Mismatch %s: expected %0d actual %0d", test_name, accepted, decoded);
         errors++;
      end
      finish_test();

      $display("tests %0d, checks %0d, errors %0d, packets %0d, dropped %0d",
               tests, checks, errors, decoded, dropped);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
src/etx_pkg.sv
src/etx_fifo.sv
src/etx_protocol.sv
src/etx_serializer.sv
src/etx_top.sv
bench/etx_sva.sv
bench/etx_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= etx_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
